//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_stage_tb
FILELIST  ?= mem_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS) source/mem_config.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/mem_stage_tb.sv
`timescale 1ns/10ps

module mem_stage_tb;

    import mem_op_pkg::*;

    localparam int N_FILL      = 256;
    localparam int N_DIRECTED  = 63;
    localparam int N_RANDOM    = 300;
    localparam int CYCLE_LIMIT = 4 * (N_FILL + N_DIRECTED + N_RANDOM) + 100;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        req_valid_i;
    logic        req_ready_o;
    mem_req_t    req_i;
    logic        flush_i;
    logic        rsp_valid_o;
    logic        rsp_ready_i;
    mem_rsp_t    rsp_o;

    logic [31:0] lfsr_q;
    logic        bp_en;
    logic [7:0]  model [1024];
    mem_rsp_t    exp_q [$];
    mem_rsp_t    exp_rsp;
    mem_rsp_t    held_rsp;
    logic        ready_exp;
    logic        held = 1'b0;
    logic        accept_seen = 1'b0;
    int          err_count = 0;
    int          rsp_count = 0;
    int          cycle_count = 0;

    mem_stage DUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (req_i),
        .flush_i     (flush_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o)
    );

    always #10 clk_i = ~clk_i;

    // ************************************************************
    // stimulus helpers.
    // ************************************************************

    // fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = 32'b0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] fill_word(input logic [7:0] w);
        return {w ^ 8'ha5, ~w, w + 8'h3c, w};
    endfunction

    function automatic mem_req_t make_req(input access_op_e op, input access_sz_e sz,
                                          input logic uns, input logic [4:0] rd,
                                          input logic [31:0] addr, input logic [31:0] wdata);
        mem_req_t r;
        r.op          = op;
        r.sz          = sz;
        r.is_unsigned = uns;
        r.reg_addr    = rd;
        r.addr        = addr;
        r.wdata       = wdata;
        return r;
    endfunction

    // the model is little endian, byte offset 0 is the least significant byte.
    function automatic mem_rsp_t expected_rsp(input mem_req_t r, input logic fl);
        mem_rsp_t    rsp;
        int          a;
        int          n;
        logic [31:0] v;
        logic        bad;
        a   = int'(r.addr[9:0]);
        n   = (r.sz == SZ_BYTE) ? 1 : ((r.sz == SZ_HALF) ? 2 : 4);
        bad = (r.op != OP_PASS) && ((int'(r.addr[1:0]) % n) != 0);
        rsp.reg_addr  = r.reg_addr;
        rsp.align_err = bad;
        rsp.data      = r.wdata;
        if (bad) begin
            rsp.data = 32'b0;
        end else if (r.op == OP_STORE) begin
            if (!fl) begin
                for (int i = 0; i < n; i++) begin
                    model[a + i] = r.wdata[8*i +: 8];
                end
            end
        end else if (r.op == OP_LOAD) begin
            v = 32'b0;
            for (int i = 0; i < n; i++) begin
                v[8*i +: 8] = model[a + i];
            end
            if (!r.is_unsigned && n == 1) begin
                v[31:8] = {24{v[7]}};
            end
            if (!r.is_unsigned && n == 2) begin
                v[31:16] = {16{v[15]}};
            end
            rsp.data = v;
        end
        return rsp;
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        if (bp_en) begin
            rsp_ready_i = |rand_bits(2);
        end else begin
            rsp_ready_i = 1'b1;
        end
    endtask

    // outputs are sampled at the falling edge, where they are settled.
    task automatic send_req(input mem_req_t r, input logic fl);
        logic done;
        done        = 1'b0;
        req_valid_i = 1'b1;
        req_i       = r;
        flush_i     = fl;
        while (!done) begin
            @(negedge clk_i);
            if (req_ready_o) begin
                done = 1'b1;
            end
            next_cycle();
        end
        exp_q.push_back(expected_rsp(r, fl));
        req_valid_i = 1'b0;
        flush_i     = 1'b0;
    endtask

    // ************************************************************
    // response checker.
    // ************************************************************

    always @(negedge clk_i) begin
        if (rst_n_i) begin
            // the stage is free when nothing is outstanding or the response drains now.
            ready_exp = (exp_q.size() == 0) || rsp_ready_i;
            if (req_ready_o !== ready_exp) begin
                $display("Fail at %0t: req_ready_o expected %b actual %b",
                         $time, ready_exp, req_ready_o);
                err_count++;
            end
            if (accept_seen && !rsp_valid_o) begin
                $display("Error at %0t: no response one cycle after an accepted request", $time);
                err_count++;
            end
            if (held && !rsp_valid_o) begin
                $display("Error at %0t: a held response was dropped before it was consumed",
                         $time);
                err_count++;
            end
            if (held && rsp_valid_o && rsp_o !== held_rsp) begin
                $display("Fail at %0t: rsp_o held %h actual %h", $time, held_rsp, rsp_o);
                err_count++;
            end
            if (rsp_valid_o && rsp_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: response consumed with nothing expected", $time);
                    err_count++;
                end else begin
                    exp_rsp = exp_q.pop_front();
                    rsp_count++;
                    if (rsp_o.data !== exp_rsp.data) begin
                        $display("Fail at %0t: rsp_o.data expected %08h actual %08h",
                                 $time, exp_rsp.data, rsp_o.data);
                        err_count++;
                    end
                    if (rsp_o.reg_addr !== exp_rsp.reg_addr) begin
                        $display("Fail at %0t: rsp_o.reg_addr expected %0d actual %0d",
                                 $time, exp_rsp.reg_addr, rsp_o.reg_addr);
                        err_count++;
                    end
                    if (rsp_o.align_err !== exp_rsp.align_err) begin
                        $display("Fail at %0t: rsp_o.align_err expected %b actual %b",
                                 $time, exp_rsp.align_err, rsp_o.align_err);
                        err_count++;
                    end
                end
            end
            held        = rsp_valid_o && !rsp_ready_i;
            held_rsp    = rsp_o;
            accept_seen = req_valid_i && req_ready_o;
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Error: timeout after %0d cycles, the stage stopped responding",
                     cycle_count);
            $display("errors: %0d, responses checked: %0d", err_count + 1, rsp_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ************************************************************
    // test sequence.
    // ************************************************************

    initial begin
        mem_req_t    r;
        access_op_e  op;
        access_sz_e  sz;
        logic [31:0] rb;
        logic [31:0] pat;
        logic        fl;
        lfsr_q      = 32'h78855ba5;
        bp_en       = 1'b0;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        flush_i     = 1'b0;
        rsp_ready_i = 1'b1;
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        if (rsp_valid_o !== 1'b0 || req_ready_o !== 1'b1) begin
            $display("Error at %0t: handshake outputs are not idle after reset", $time);
            err_count++;
        end

        // every RAM word gets a known value first.
        for (int i = 0; i < N_FILL; i++) begin
            send_req(make_req(OP_STORE, SZ_WORD, 1'b0, 5'(i), 32'(4 * i), fill_word(8'(i))),
                     1'b0);
        end

        // word store and load, then pass requests.
        for (int k = 0; k < 4; k++) begin
            send_req(make_req(OP_STORE, SZ_WORD, 1'b0, 5'(k), 32'h100 + 32'(16 * k),
                              32'hc0de_5a00 + 32'(k)), 1'b0);
            send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, 5'(k + 8), 32'h100 + 32'(16 * k), 32'h0),
                     1'b0);
        end
        send_req(make_req(OP_PASS, SZ_WORD, 1'b0, 5'd17, 32'h0, 32'h1234_abcd), 1'b0);
        send_req(make_req(OP_PASS, SZ_BYTE, 1'b1, 5'd18, 32'h3, 32'hfeed_beef), 1'b0);

        // narrow stores, each followed by a word load of the same word.
        for (int lane = 0; lane < 4; lane++) begin
            send_req(make_req(OP_STORE, SZ_BYTE, 1'b0, 5'd1, 32'h200 + 32'(lane),
                              32'hffff_ff11 * 32'(lane + 1)), 1'b0);
            send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, 5'd2, 32'h200, 32'h0), 1'b0);
        end
        for (int h = 0; h < 2; h++) begin
            send_req(make_req(OP_STORE, SZ_HALF, 1'b0, 5'd3, 32'h204 + 32'(2 * h),
                              32'h5555_a001 + 32'(h)), 1'b0);
            send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, 5'd4, 32'h204, 32'h0), 1'b0);
        end

        // both sign polarities on every byte lane and on both halves.
        for (int p = 0; p < 2; p++) begin
            pat = (p == 0) ? 32'h807f_fe01 : 32'h7f80_01fe;
            send_req(make_req(OP_STORE, SZ_WORD, 1'b0, 5'd5, 32'h300 + 32'(4 * p), pat), 1'b0);
            for (int lane = 0; lane < 4; lane++) begin
                for (int u = 0; u < 2; u++) begin
                    send_req(make_req(OP_LOAD, SZ_BYTE, 1'(u), 5'(lane + 4 * u),
                                      32'h300 + 32'(4 * p + lane), 32'h0), 1'b0);
                end
            end
            for (int h = 0; h < 2; h++) begin
                for (int u = 0; u < 2; u++) begin
                    send_req(make_req(OP_LOAD, SZ_HALF, 1'(u), 5'(h + 2 * u),
                                      32'h300 + 32'(4 * p + 2 * h), 32'h0), 1'b0);
                end
            end
        end

        // misaligned accesses, then an aligned load of the untouched word.
        for (int off = 1; off < 4; off++) begin
            send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, 5'd6, 32'h380 + 32'(off), 32'h0), 1'b0);
            send_req(make_req(OP_STORE, SZ_WORD, 1'b0, 5'd7, 32'h380 + 32'(off),
                              32'hdead_dead), 1'b0);
        end
        for (int off = 1; off < 4; off += 2) begin
            send_req(make_req(OP_LOAD, SZ_HALF, 1'b1, 5'd8, 32'h380 + 32'(off), 32'h0), 1'b0);
            send_req(make_req(OP_STORE, SZ_HALF, 1'b0, 5'd9, 32'h380 + 32'(off),
                              32'hbad0_bad0), 1'b0);
        end
        send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, 5'd10, 32'h380, 32'h0), 1'b0);

        // flushed stores leave memory alone.
        send_req(make_req(OP_STORE, SZ_WORD, 1'b0, 5'd11, 32'h3c0, 32'h0bad_f00d), 1'b1);
        send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, 5'd12, 32'h3c0, 32'h0), 1'b0);
        send_req(make_req(OP_STORE, SZ_BYTE, 1'b0, 5'd13, 32'h3c5, 32'h0000_00ee), 1'b1);
        send_req(make_req(OP_LOAD, SZ_WORD, 1'b0, 5'd14, 32'h3c4, 32'h0), 1'b0);

        // random traffic with idle gaps and response back-pressure.
        bp_en = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            rb = rand_bits(1);
            if (rb[0]) begin
                next_cycle();
            end
            rb = rand_bits(2);
            op = (rb[1:0] == 2'd3) ? OP_LOAD : access_op_e'(rb[1:0]);
            rb = rand_bits(2);
            sz = (rb[1:0] == 2'd3) ? SZ_WORD : access_sz_e'(rb[1:0]);
            r  = make_req(op, sz, rand_bits(1) != 32'b0, 5'(rand_bits(5)), rand_bits(10),
                          rand_bits(32));
            rb = rand_bits(3);
            fl = &rb[2:0];
            send_req(r, fl);
        end
        bp_en = 1'b0;

        for (int i = 0; i < 8 && exp_q.size() != 0; i++) begin
            next_cycle();
        end
        if (exp_q.size() != 0) begin
            $display("Error: %0d expected responses never arrived", exp_q.size());
            err_count++;
        end

        $display("errors: %0d, responses checked: %0d", err_count, rsp_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- mem_stage.f
+incdir+source
source/mem_op_pkg.sv
source/mem_bus_pkg.sv
source/mem_access_ctrl.sv
source/store_formatter.sv
source/load_aligner.sv
source/data_ram.sv
source/mem_stage.sv
bench/mem_stage_tb.sv

//--- source/data_ram.sv
`timescale 1ns/10ps

`include "mem_config.svh"

module data_ram (
    input  logic                    clk_i,
    input  mem_bus_pkg::ram_port_t  port_i,
    output mem_bus_pkg::mem_word_u  rdata_o
);

    localparam int DEPTH = 1 << `MEM_ADDR_BITS;

    logic [`MEM_DATA_BITS-1:0] mem [DEPTH];

    // read data only moves on an enabled read, so it holds under back-pressure.
    always_ff @(posedge clk_i) begin
        if (port_i.en) begin
            if (port_i.we) begin
                for (int i = 0; i < 4; i++) begin
                    if (port_i.be[i]) begin
                        mem[port_i.waddr][8*i +: 8] <= port_i.wdata.byte_lane[i];
                    end
                end
            end else begin
                rdata_o.word <= mem[port_i.waddr];
            end
        end
    end

endmodule

//--- source/load_aligner.sv
`timescale 1ns/10ps

module load_aligner (
    input  mem_op_pkg::access_sz_e  sz_i,
    input  logic [1:0]              lane_i,
    input  logic                    is_unsigned_i,
    input  mem_bus_pkg::mem_word_u  rdata_i,
    output logic [31:0]             data_o
);

    import mem_op_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // address bit 1 picks the half, bits 1:0 pick the byte.
    assign byte_sel = rdata_i.byte_lane[lane_i];
    assign half_sel = rdata_i.half[lane_i[1]];

    always_comb begin
        case (sz_i)
            SZ_BYTE: begin
                if (is_unsigned_i) begin
                    data_o = {24'b0, byte_sel};
                end else begin
                    data_o = {{24{byte_sel[7]}}, byte_sel};
                end
            end
            SZ_HALF: begin
                if (is_unsigned_i) begin
                    data_o = {16'b0, half_sel};
                end else begin
                    data_o = {{16{half_sel[15]}}, half_sel};
                end
            end
            default: begin
                data_o = rdata_i.word;
            end
        endcase
    end

endmodule

//--- source/mem_access_ctrl.sv
`timescale 1ns/10ps

`include "mem_config.svh"

module mem_access_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  mem_op_pkg::mem_req_t    req_i,
    input  logic                    flush_i,
    output logic                    rsp_valid_o,
    input  logic                    rsp_ready_i,
    output mem_op_pkg::mem_rsp_t    rsp_o,
    input  logic [3:0]              fmt_be_i,
    input  mem_bus_pkg::mem_word_u  fmt_wdata_i,
    input  logic [31:0]             load_data_i,
    output mem_bus_pkg::ram_port_t  ram_o,
    output mem_op_pkg::access_sz_e  ld_sz_o,
    output logic                    ld_unsigned_o,
    output logic [1:0]              ld_lane_o
);

    import mem_op_pkg::*;

    logic        accept;
    logic        is_mem;
    logic        misaligned;
    logic        align_err;
    logic        ram_en;
    logic        rsp_valid_q;
    access_op_e  op_q;
    access_sz_e  sz_q;
    logic        unsigned_q;
    logic [1:0]  lane_q;
    logic [4:0]  reg_addr_q;
    logic [31:0] data_q;
    logic        err_q;

    // ************************************************************
    // handshake.
    // ************************************************************

    // a new request may enter when the response slot is free or drains now.
    assign req_ready_o = !rsp_valid_q || rsp_ready_i;
    assign accept      = req_valid_i && req_ready_o;
    assign rsp_valid_o = rsp_valid_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // ************************************************************
    // alignment check and RAM strobes.
    // ************************************************************

    assign is_mem = (req_i.op == OP_LOAD) || (req_i.op == OP_STORE);

    always_comb begin
        case (req_i.sz)
            SZ_HALF: misaligned = req_i.addr[0];
            SZ_WORD: misaligned = |req_i.addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    assign align_err = is_mem && misaligned;
    assign ram_en    = accept && is_mem && !align_err;

    // a flushed store turns into a harmless read.
    always_comb begin
        ram_o.en    = ram_en;
        ram_o.we    = ram_en && (req_i.op == OP_STORE) && !flush_i;
        ram_o.be    = fmt_be_i;
        ram_o.waddr = req_i.addr[`MEM_ADDR_BITS+1:2];
        ram_o.wdata = fmt_wdata_i;
    end

    // ************************************************************
    // fields of the request in flight.
    // ************************************************************

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q       <= req_i.op;
            sz_q       <= req_i.sz;
            unsigned_q <= req_i.is_unsigned;
            lane_q     <= req_i.addr[1:0];
            reg_addr_q <= req_i.reg_addr;
            data_q     <= req_i.wdata;
            err_q      <= align_err;
        end
    end

    assign ld_sz_o       = sz_q;
    assign ld_unsigned_o = unsigned_q;
    assign ld_lane_o     = lane_q;

    // load data arrives from the RAM in the response cycle.
    always_comb begin
        rsp_o.reg_addr  = reg_addr_q;
        rsp_o.align_err = err_q;
        if (err_q) begin
            rsp_o.data = 32'b0;
        end else if (op_q == OP_LOAD) begin
            rsp_o.data = load_data_i;
        end else begin
            rsp_o.data = data_q;
        end
    end

endmodule

//--- source/mem_bus_pkg.sv
package mem_bus_pkg;

    `include "mem_config.svh"

    // one RAM word seen whole, as two halves or as four byte lanes.
    // lane 0 is the least significant byte.
    typedef union packed {
        logic [`MEM_DATA_BITS-1:0] word;
        logic [1:0][15:0]          half;
        logic [3:0][7:0]           byte_lane;
    } mem_word_u;

    // single port of the data RAM.
    typedef struct packed {
        logic                      en;
        logic                      we;
        logic [3:0]                be;
        logic [`MEM_ADDR_BITS-1:0] waddr;
        mem_word_u                 wdata;
    } ram_port_t;

endpackage

//--- source/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// ************************************************************
// data RAM geometry.
// ************************************************************

// word address width of the local data RAM, 256 words.
`define MEM_ADDR_BITS 8

// width of one RAM word.
`define MEM_DATA_BITS 32

`endif

//--- source/mem_op_pkg.sv
package mem_op_pkg;

    // ************************************************************
    // operation and size encodings.
    // ************************************************************

    // load moves memory to a register, store moves a register to memory.
    typedef enum logic [1:0] {
        OP_PASS  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } access_op_e;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } access_sz_e;

    // ************************************************************
    // request and response of the memory stage.
    // ************************************************************

    typedef struct packed {
        access_op_e  op;
        access_sz_e  sz;
        logic        is_unsigned;
        logic [4:0]  reg_addr;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    // align_err is only set for loads and stores.
    typedef struct packed {
        logic [31:0] data;
        logic [4:0]  reg_addr;
        logic        align_err;
    } mem_rsp_t;

endpackage

//--- source/mem_stage.sv
`timescale 1ns/10ps

module mem_stage (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  mem_op_pkg::mem_req_t  req_i,
    input  logic                  flush_i,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output mem_op_pkg::mem_rsp_t  rsp_o
);

    import mem_op_pkg::*;
    import mem_bus_pkg::*;

    logic [3:0]  fmt_be;
    mem_word_u   fmt_wdata;
    logic [31:0] load_data;
    ram_port_t   ram_port;
    mem_word_u   ram_rdata;
    access_sz_e  ld_sz;
    logic        ld_unsigned;
    logic [1:0]  ld_lane;

    mem_access_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_i         (req_i),
        .flush_i       (flush_i),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_ready_i   (rsp_ready_i),
        .rsp_o         (rsp_o),
        .fmt_be_i      (fmt_be),
        .fmt_wdata_i   (fmt_wdata),
        .load_data_i   (load_data),
        .ram_o         (ram_port),
        .ld_sz_o       (ld_sz),
        .ld_unsigned_o (ld_unsigned),
        .ld_lane_o     (ld_lane)
    );

    // formats the incoming request in its accept cycle.
    store_formatter u_store_fmt (
        .sz_i    (req_i.sz),
        .lane_i  (req_i.addr[1:0]),
        .wdata_i (req_i.wdata),
        .be_o    (fmt_be),
        .wdata_o (fmt_wdata)
    );

    // works on the registered fields of the request in flight.
    load_aligner u_load_align (
        .sz_i          (ld_sz),
        .lane_i        (ld_lane),
        .is_unsigned_i (ld_unsigned),
        .rdata_i       (ram_rdata),
        .data_o        (load_data)
    );

    data_ram u_ram (
        .clk_i   (clk_i),
        .port_i  (ram_port),
        .rdata_o (ram_rdata)
    );

endmodule

//--- source/store_formatter.sv
`timescale 1ns/10ps

module store_formatter (
    input  mem_op_pkg::access_sz_e  sz_i,
    input  logic [1:0]              lane_i,
    input  logic [31:0]             wdata_i,
    output logic [3:0]              be_o,
    output mem_bus_pkg::mem_word_u  wdata_o
);

    import mem_op_pkg::*;

    // narrow stores are copied to every lane, so be_o alone picks the target.
    always_comb begin
        case (sz_i)
            SZ_BYTE: begin
                be_o              = 4'b0001 << lane_i;
                wdata_o.byte_lane = {4{wdata_i[7:0]}};
            end
            SZ_HALF: begin
                be_o         = lane_i[1] ? 4'b1100 : 4'b0011;
                wdata_o.half = {2{wdata_i[15:0]}};
            end
            default: begin
                be_o         = 4'b1111;
                wdata_o.word = wdata_i;
            end
        endcase
    end

endmodule
